// File: wasm_config.svh
`ifndef WASM_CONFIG_SVH
`define WASM_CONFIG_SVH

// Code memory
`define WASM_CODE_BYTES 64
`define WASM_CODE_AW 6

// One code read returns this many bytes, lowest address first
`define WASM_WINDOW_BYTES 16

// Operand stack entries
`define WASM_STACK_DEPTH 8

`endif

// File: wasm_pkg.sv
`default_nettype none

package wasm_pkg;

  // WebAssembly opcode bytes
  typedef enum logic [7:0] {
    op_unreachable = 8'h00,
    op_nop         = 8'h01,
    op_end         = 8'h0B,
    op_i32_const   = 8'h41,
    op_i64_const   = 8'h42,
    op_f32_const   = 8'h43,
    op_f64_const   = 8'h44
  } opcode_e;

  typedef enum logic [1:0] {
    vt_i32 = 2'd0,
    vt_i64 = 2'd1,
    vt_f32 = 2'd2,
    vt_f64 = 2'd3
  } value_type_e;

  typedef struct packed {
    value_type_e vtype;
    logic [63:0] value;
  } stack_entry_t;

  // Codes 2 and 3 kept free for pop and other ops
  typedef enum logic [1:0] {
    st_none = 2'd0,
    st_push = 2'd1
  } stack_op_e;

  typedef enum logic [2:0] {
    trap_none        = 3'd0,
    trap_fetch       = 3'd2,
    trap_unreachable = 3'd3,
    trap_bad_opcode  = 3'd4,
    trap_operand     = 3'd5,
    trap_overflow    = 3'd6
  } trap_e;

  // Core sequencing
  typedef enum logic [2:0] {
    FETCH   = 3'd0,
    FETCH2  = 3'd1,
    EXEC    = 3'd2,
    EXEC2   = 3'd3,
    MEMORY  = 3'd4,
    MEMORY2 = 3'd5
  } core_step_e;

endpackage

`default_nettype wire

// File: code_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "wasm_config.svh"

module code_memory (
  input  wire                              clk,
  input  wire                              we,
  input  wire  [`WASM_CODE_AW-1:0]         waddr,
  input  wire  [7:0]                       wdata,
  input  wire  [`WASM_CODE_AW-1:0]         addr,
  input  wire  [3:0]                       extra,
  output logic [`WASM_WINDOW_BYTES*8-1:0]  data,
  output logic                             error
);

  // One spare bit so that addresses past the end can be seen
  localparam int AW1 = `WASM_CODE_AW + 1;

  logic [7:0]                      mem [`WASM_CODE_BYTES];
  logic [`WASM_WINDOW_BYTES*8-1:0] window;

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  for (genvar i = 0; i < `WASM_WINDOW_BYTES; i++) begin : g_window
    logic [AW1-1:0] idx;

    assign idx = {1'b0, addr} + AW1'(i);
    // Bytes beyond the end read as zero
    assign window[i*8 +: 8] = (idx < AW1'(`WASM_CODE_BYTES)) ?
                              mem[idx[`WASM_CODE_AW-1:0]] : 8'h00;
  end

  always_ff @(posedge clk) begin
    data  <= window;
    error <= ({1'b0, addr} + AW1'(extra)) >= AW1'(`WASM_CODE_BYTES);
  end

endmodule

`default_nettype wire

// File: leb128_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module leb128_decoder (
  input  wire  [79:0] bytes,
  output logic [63:0] value,
  output logic [3:0]  len
);

  // Seven payload bits per byte, ten bytes at most
  logic [69:0] raw;
  logic        done;
  logic        sign;

  always_comb begin
    raw  = '0;
    len  = 4'd10;
    done = 1'b0;
    // Without a terminating byte the last byte gives the sign
    sign = bytes[78];

    for (int i = 0; i < 10; i++) begin
      if (!done) begin
        raw[i*7 +: 7] = bytes[i*8 +: 7];
        if (!bytes[i*8 + 7]) begin
          done = 1'b1;
          len  = 4'(i + 1);
          sign = bytes[i*8 + 6];
        end
      end
    end
  end

  // Sign extension above the gathered bits
  always_comb begin
    for (int b = 0; b < 64; b++) begin
      if (b < 7 * int'(len)) begin
        value[b] = raw[b];
      end else begin
        value[b] = sign;
      end
    end
  end

endmodule

`default_nettype wire

// File: operand_stack.sv
`timescale 1ns/1ps
`default_nettype none

`include "wasm_config.svh"

module operand_stack import wasm_pkg::*; (
  input  wire          clk,
  input  wire          reset,
  input  wire          stack_op_e op,
  input  wire          stack_entry_t data,
  output stack_entry_t tos,
  output logic         empty,
  output logic         overflow
);

  localparam int DEPTH = `WASM_STACK_DEPTH;
  // Pointer counts entries, so it needs to hold DEPTH itself
  localparam int PW    = $clog2(DEPTH + 1);
  localparam int IW    = $clog2(DEPTH);

  stack_entry_t  entries [DEPTH];
  logic [PW-1:0] ptr;
  logic          full;
  logic          push_ok;

  assign empty    = (ptr == '0);
  assign full     = (ptr == PW'(DEPTH));
  assign push_ok  = (op == st_push) && !full;
  assign overflow = (op == st_push) && full;

  // Entry below the pointer is the top
  assign tos = empty ? '0 : entries[IW'(ptr - 1'b1)];

  always_ff @(posedge clk) begin
    if (reset) begin
      ptr <= '0;
    end else if (push_ok) begin
      ptr <= ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push_ok) begin
      entries[ptr[IW-1:0]] <= data;
    end
  end

endmodule

`default_nettype wire

// File: wasm_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "wasm_config.svh"

module wasm_core import wasm_pkg::*; (
  input  wire                             clk,
  input  wire                             reset,

  output logic [`WASM_CODE_AW-1:0]        rom_addr,
  output logic [3:0]                      rom_extra,
  input  wire  [`WASM_WINDOW_BYTES*8-1:0] rom_data,
  input  wire                             rom_error,

  output logic [79:0]                     leb_bytes,
  input  wire  [63:0]                     leb_value,
  input  wire  [3:0]                      leb_len,

  output stack_op_e                       stack_op,
  output stack_entry_t                    push_entry,
  input  wire  stack_entry_t              tos,
  input  wire                             empty,
  input  wire                             overflow,

  output logic [63:0]                     result,
  output value_type_e                     result_type,
  output logic                            result_empty,
  output logic                            result_valid,
  output trap_e                           trap
);

  localparam int AW = `WASM_CODE_AW;

  core_step_e    step;
  logic [AW-1:0] pc;
  opcode_e       opcode;

  always_ff @(posedge clk) begin
    if (reset) begin
      step         <= FETCH;
      pc           <= '0;
      trap         <= trap_none;
      stack_op     <= st_none;
      result_valid <= 1'b0;
      rom_addr     <= '0;
      rom_extra    <= '0;
    end else begin
      // Strobes last a single cycle
      stack_op     <= st_none;
      result_valid <= 1'b0;

      if (trap == trap_none) begin
        if (overflow) begin
          trap <= trap_overflow;
        end else begin
          case (step)
            FETCH: begin
              rom_addr  <= pc;
              rom_extra <= 4'd0;
              pc        <= pc + 1'b1;
              step      <= FETCH2;
            end

            FETCH2: begin
              step <= EXEC;
            end

            EXEC: begin
              if (rom_error) begin
                trap <= trap_fetch;
              end else begin
                opcode <= opcode_e'(rom_data[7:0]);
                // Operand window starts right after the opcode
                rom_addr <= pc;
                step     <= EXEC2;

                case (rom_data[7:0])
                  op_unreachable: trap <= trap_unreachable;
                  op_nop:         step <= FETCH;
                  op_end: begin
                    result       <= tos.value;
                    result_type  <= tos.vtype;
                    result_empty <= empty;
                    result_valid <= 1'b1;
                    step         <= FETCH;
                  end
                  op_i32_const:   rom_extra <= 4'd4;
                  op_i64_const:   rom_extra <= 4'd9;
                  op_f32_const:   rom_extra <= 4'd3;
                  op_f64_const:   rom_extra <= 4'd7;
                  default:        trap <= trap_bad_opcode;
                endcase
              end
            end

            EXEC2: begin
              step <= MEMORY;
            end

            MEMORY: begin
              if (rom_error) begin
                trap <= trap_operand;
              end else begin
                case (opcode)
                  op_i32_const: begin
                    leb_bytes <= {40'd0, rom_data[39:0]};
                    step      <= MEMORY2;
                  end
                  op_i64_const: begin
                    leb_bytes <= rom_data[79:0];
                    step      <= MEMORY2;
                  end
                  // Float operands are raw little-endian bytes
                  op_f32_const: begin
                    stack_op   <= st_push;
                    push_entry <= '{vtype: vt_f32, value: {32'd0, rom_data[31:0]}};
                    pc         <= pc + AW'(4);
                    step       <= FETCH;
                  end
                  op_f64_const: begin
                    stack_op   <= st_push;
                    push_entry <= '{vtype: vt_f64, value: rom_data[63:0]};
                    pc         <= pc + AW'(8);
                    step       <= FETCH;
                  end
                  default: step <= FETCH;
                endcase
              end
            end

            MEMORY2: begin
              // Decoder output settles from the bytes latched in MEMORY
              stack_op         <= st_push;
              push_entry.value <= leb_value;
              push_entry.vtype <= (opcode == op_i64_const) ? vt_i64 : vt_i32;
              pc               <= pc + AW'(leb_len);
              step             <= FETCH;
            end

            default: step <= FETCH;
          endcase
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: wasm_cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "wasm_config.svh"

module wasm_cpu import wasm_pkg::*; (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       prog_we,
  input  wire  [`WASM_CODE_AW-1:0]  prog_addr,
  input  wire  [7:0]                prog_data,
  output logic [63:0]               result,
  output value_type_e               result_type,
  output logic                      result_empty,
  output logic                      result_valid,
  output trap_e                     trap
);

  logic [`WASM_CODE_AW-1:0]        rom_addr;
  logic [3:0]                      rom_extra;
  logic [`WASM_WINDOW_BYTES*8-1:0] rom_data;
  logic                            rom_error;

  logic [79:0]  leb_bytes;
  logic [63:0]  leb_value;
  logic [3:0]   leb_len;

  stack_op_e    stack_op;
  stack_entry_t push_entry;
  stack_entry_t tos;
  logic         empty;
  logic         overflow;

  wasm_core u_core (
    .clk          (clk),
    .reset        (reset),
    .rom_addr     (rom_addr),
    .rom_extra    (rom_extra),
    .rom_data     (rom_data),
    .rom_error    (rom_error),
    .leb_bytes    (leb_bytes),
    .leb_value    (leb_value),
    .leb_len      (leb_len),
    .stack_op     (stack_op),
    .push_entry   (push_entry),
    .tos          (tos),
    .empty        (empty),
    .overflow     (overflow),
    .result       (result),
    .result_type  (result_type),
    .result_empty (result_empty),
    .result_valid (result_valid),
    .trap         (trap)
  );

  // Program bytes come in through the write port
  code_memory u_code_memory (
    .clk   (clk),
    .we    (prog_we),
    .waddr (prog_addr),
    .wdata (prog_data),
    .addr  (rom_addr),
    .extra (rom_extra),
    .data  (rom_data),
    .error (rom_error)
  );

  leb128_decoder u_leb128 (
    .bytes (leb_bytes),
    .value (leb_value),
    .len   (leb_len)
  );

  operand_stack u_stack (
    .clk      (clk),
    .reset    (reset),
    .op       (stack_op),
    .data     (push_entry),
    .tos      (tos),
    .empty    (empty),
    .overflow (overflow)
  );

endmodule

`default_nettype wire

// File: wasm_cpu_sva.sv
`timescale 1ns/1ps
`default_nettype none

module wasm_cpu_sva import wasm_pkg::*; (
  input wire            clk,
  input wire            reset,
  input wire trap_e     trap,
  input wire            result_valid,
  input wire stack_op_e stack_op
);

  // Once set, a trap holds until the next reset
  trap_sticky: assert property (@(posedge clk) disable iff (reset)
    (trap != trap_none) |=> $stable(trap))
    else $error("trap code changed while no reset was applied");

  result_pulse: assert property (@(posedge clk) disable iff (reset)
    result_valid |=> !result_valid)
    else $error("result_valid stayed high for more than one cycle");

  no_result_on_trap: assert property (@(posedge clk) disable iff (reset)
    (trap != trap_none) |-> !result_valid)
    else $error("result_valid raised while a trap was set");

  // Synchronous reset clears the strobes and the trap
  reset_state: assert property (@(posedge clk)
    reset |=> (stack_op == st_none) && !result_valid && (trap == trap_none))
    else $error("core left idle values missing after reset");

endmodule

bind wasm_core wasm_cpu_sva u_sva (
  .clk          (clk),
  .reset        (reset),
  .trap         (trap),
  .result_valid (result_valid),
  .stack_op     (stack_op)
);

`default_nettype wire

// File: wasm_cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "wasm_config.svh"

module wasm_cpu_tb import wasm_pkg::*; ();

  localparam int NUM_TESTS = 18;
  localparam int MAX_BYTES = 20;

  // One program and the outcome it should give
  typedef struct packed {
    logic [MAX_BYTES*8-1:0] code;
    logic [4:0]             len;
    logic [5:0]             lead_nops;
    logic [63:0]            value;
    value_type_e            vtype;
    logic                   empty;
    trap_e                  trap;
  } test_entry_t;

  logic                     clk;
  logic                     reset;
  logic                     prog_we;
  logic [`WASM_CODE_AW-1:0] prog_addr;
  logic [7:0]               prog_data;
  logic [63:0]              result;
  value_type_e              result_type;
  logic                     result_empty;
  logic                     result_valid;
  trap_e                    trap;

  test_entry_t tests [NUM_TESTS];
  string       names [NUM_TESTS];
  int          n_tests;
  int          errors;
  int          bad_tests;

  wasm_cpu dut (
    .clk          (clk),
    .reset        (reset),
    .prog_we      (prog_we),
    .prog_addr    (prog_addr),
    .prog_data    (prog_data),
    .result       (result),
    .result_type  (result_type),
    .result_empty (result_empty),
    .result_valid (result_valid),
    .trap         (trap)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    repeat (NUM_TESTS * 200) @(posedge clk);
    $display("Watchdog expired before all programs reached end or a trap");
    $display("test failed");
    $finish;
  end

  task automatic check_result(input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("** Error: result = 0x%h, expected 0x%h", got, exp);
      errors++;
    end
  endtask

  task automatic check_type(input value_type_e got, input value_type_e exp);
    if (got !== exp) begin
      $display("** Error: result_type = 0x%h, expected 0x%h", got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_trap(input trap_e got, input trap_e exp);
    if (got !== exp) begin
      $display("** Error: trap = 0x%h, expected 0x%h", got, exp);
      errors++;
    end
  endtask

  // Program bytes are given in program order, first byte highest
  task automatic add_test(input string name, input logic [MAX_BYTES*8-1:0] code_be,
                          input int len, input int lead, input logic [63:0] exp_value,
                          input value_type_e exp_type, input logic exp_empty,
                          input trap_e exp_trap);
    test_entry_t e;
    e = '0;
    for (int i = 0; i < len; i++) begin
      e.code[i*8 +: 8] = code_be[(len-1-i)*8 +: 8];
    end
    e.len       = 5'(len);
    e.lead_nops = 6'(lead);
    e.value     = exp_value;
    e.vtype     = exp_type;
    e.empty     = exp_empty;
    e.trap      = exp_trap;
    tests[n_tests] = e;
    names[n_tests] = name;
    n_tests++;
  endtask

  function automatic logic [7:0] code_byte(input test_entry_t e, input int addr);
    int off;
    off = addr - int'(e.lead_nops);
    if (off < 0) return 8'(op_nop);
    if (off < int'(e.len)) return e.code[off*8 +: 8];
    // Zero bytes decode as unreachable
    return 8'h00;
  endfunction

  task automatic run_test(input int idx);
    test_entry_t e;
    int          errs_at_start;
    string       verdict;
    e             = tests[idx];
    errs_at_start = errors;
    // The whole memory is written while the core sits in reset
    @(posedge clk);
    reset <= 1'b1;
    for (int a = 0; a < `WASM_CODE_BYTES; a++) begin
      @(posedge clk);
      prog_we   <= 1'b1;
      prog_addr <= `WASM_CODE_AW'(a);
      prog_data <= code_byte(e, a);
    end
    @(posedge clk);
    prog_we <= 1'b0;
    @(posedge clk);
    reset <= 1'b0;
    do begin
      @(negedge clk);
    end while (!result_valid && trap == trap_none);
    check_trap(trap, e.trap);
    if (e.trap == trap_none) begin
      check_result(result, e.value);
      check_type(result_type, e.vtype);
      check_flag("result_empty", result_empty, e.empty);
    end else begin
      check_flag("result_valid", result_valid, 1'b0);
    end
    if (errors == errs_at_start) begin
      verdict = "ok";
    end else begin
      verdict = "mismatch";
      bad_tests++;
    end
    $display("test %0d (%s): %s", idx, names[idx], verdict);
  endtask

  initial begin
    logic [MAX_BYTES*8-1:0] code;
    logic [63:0]            value;
    logic [7:0]             rnd;
    reset     = 1'b1;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    errors    = 0;
    bad_tests = 0;
    n_tests   = 0;
    void'($urandom(96724));

    add_test("i32 zero", 160'h41_00_0B, 3, 0, 64'h0, vt_i32, 1'b0, trap_none);
    add_test("i32 -1", 160'h41_7F_0B, 3, 0, '1, vt_i32, 1'b0, trap_none);
    add_test("i32 624485", 160'h41_E5_8E_26_0B, 5, 0, 64'h9_8765, vt_i32, 1'b0, trap_none);
    add_test("i32 -128", 160'h41_80_7F_0B, 4, 0, 64'hFFFF_FFFF_FFFF_FF80, vt_i32, 1'b0,
             trap_none);
    add_test("i32 max", 160'h41_FF_FF_FF_FF_07_0B, 7, 0, 64'h7FFF_FFFF, vt_i32, 1'b0, trap_none);
    add_test("i64 min", 160'h42_80_80_80_80_80_80_80_80_80_7F_0B, 12, 0,
             64'h8000_0000_0000_0000, vt_i64, 1'b0, trap_none);
    add_test("i64 2^56", 160'h42_80_80_80_80_80_80_80_80_01_0B, 11, 0,
             64'h0100_0000_0000_0000, vt_i64, 1'b0, trap_none);
    // Second constant only decodes right if pc moved by leb_len
    add_test("i64 then i64", 160'h42_80_80_80_80_80_80_80_80_01_42_7F_0B, 13, 0, '1, vt_i64,
             1'b0, trap_none);
    add_test("f32 1.0", 160'h43_00_00_80_3F_0B, 6, 0, 64'h3F80_0000, vt_f32, 1'b0, trap_none);
    add_test("f64 pi", 160'h44_18_2D_44_54_FB_21_09_40_0B, 10, 0, 64'h4009_21FB_5444_2D18,
             vt_f64, 1'b0, trap_none);
    for (int r = 0; r < 2; r++) begin
      code  = 160'h44;
      value = '0;
      for (int b = 0; b < 8; b++) begin
        rnd              = 8'($urandom);
        code             = {code[151:0], rnd};
        value[b*8 +: 8]  = rnd;
      end
      code = {code[151:0], 8'h0B};
      add_test($sformatf("f64 random %0d", r), code, 10, 0, value, vt_f64, 1'b0, trap_none);
    end
    add_test("end only", 160'h0B, 1, 0, 64'h0, vt_i32, 1'b1, trap_none);
    add_test("nop end", 160'h01_0B, 2, 0, 64'h0, vt_i32, 1'b1, trap_none);
    add_test("nine pushes", 160'h41_01_41_01_41_01_41_01_41_01_41_01_41_01_41_01_41_01, 18, 0,
             64'h0, vt_i32, 1'b0, trap_overflow);
    add_test("unreachable", 160'h00, 1, 0, 64'h0, vt_i32, 1'b0, trap_unreachable);
    add_test("bad opcode", 160'h6A, 1, 0, 64'h0, vt_i32, 1'b0, trap_bad_opcode);
    // i64.const at 55 asks for operand bytes up to address 65
    add_test("operand past end", 160'h42, 1, 55, 64'h0, vt_i32, 1'b0, trap_operand);

    repeat (4) @(posedge clk);
    reset <= 1'b0;
    for (int i = 0; i < n_tests; i++) begin
      run_test(i);
    end
    $display("%0d programs run, %0d with mismatches, %0d check errors",
             n_tests, bad_tests, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
wasm_pkg.sv
code_memory.sv
leb128_decoder.sv
operand_stack.sv
wasm_core.sv
wasm_cpu.sv
wasm_cpu_sva.sv
wasm_cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= wasm_cpu_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= test passed
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) wasm_config.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
